/* hdl/radio_core_config.svh */
// Widths, address map and latencies of the radio core, included by RTL and testbench
`ifndef RADIO_CORE_CONFIG_SVH
`define RADIO_CORE_CONFIG_SVH

// ------------------------------
// Sample format
// ------------------------------
`define SAMP_W 32
`define COMP_W 16
`define NSPC 1

// ------------------------------
// Control port
// ------------------------------
`define CTRL_ADDR_W 20
`define CTRL_DATA_W 32

// Address bits 9:8 pick the target window
`define WIN_SEL_LSB 8

// General register window
`define REG_LOOPBACK_EN 20'h0_0000
`define REG_RADIO_WIDTH 20'h0_0004
`define REG_FEATURES_PRESENT 20'h0_0008

// Complex gain windows
`define REG_CGAIN_COEFF 20'h0_0000

// Coefficients are Q1.14
`define GAIN_FRAC_BITS 14

// Pipeline depths in radio_clk cycles
`define GAIN_LATENCY 3
`define CTRL_LATENCY 3

`endif

/* hdl/radio_ctrl_pkg.sv */
// Control port types shared by the decoder, the register targets and the response merge
`default_nettype none

`include "radio_core_config.svh"

package radio_ctrl_pkg;

  // ------------------------------
  // Request side
  // ------------------------------

  // Exactly one non-idle cycle per request
  typedef enum logic [1:0] {
    CTRL_OP_IDLE  = 2'd0,
    CTRL_OP_WRITE = 2'd1,
    CTRL_OP_READ  = 2'd2
  } ctrl_op_e;

  // Value of address bits 9:8
  typedef enum logic [1:0] {
    TGT_GENERAL  = 2'd0,
    TGT_TX_GAIN  = 2'd1,
    TGT_RX_GAIN  = 2'd2,
    TGT_UNMAPPED = 2'd3
  } ctrl_target_e;

  typedef struct packed {
    ctrl_op_e                 op;
    logic [`CTRL_ADDR_W-1:0]  addr;
    logic [`CTRL_DATA_W-1:0]  data;
  } ctrl_req_t;

  // ------------------------------
  // Response side
  // ------------------------------

  typedef enum logic [1:0] {
    STS_OKAY   = 2'd0,
    STS_CMDERR = 2'd1
  } ctrl_status_e;

  // Ack is a single-cycle pulse, data only valid with it
  typedef struct packed {
    logic                     ack;
    ctrl_status_e             status;
    logic [`CTRL_DATA_W-1:0]  data;
  } ctrl_resp_t;

endpackage

`default_nettype wire

/* hdl/radio_sample_pkg.sv */
// Sample types for the strobed TX and RX sample paths of the radio core
`default_nettype none

`include "radio_core_config.svh"

package radio_sample_pkg;

  // ------------------------------
  // Complex sample
  // ------------------------------

  // I in the upper half, Q in the lower half, as on the radio bus
  typedef struct packed {
    logic signed [`COMP_W-1:0] i;
    logic signed [`COMP_W-1:0] q;
  } iq_sample_t;

  // ------------------------------
  // Strobed beat
  // ------------------------------

  // One sample per strobe, no back-pressure
  typedef struct packed {
    logic       stb;
    iq_sample_t iq;
  } sample_beat_t;

endpackage

`default_nettype wire

/* hdl/ctrl_decoder.sv */
// Registers control requests and routes each one to a single target by address window
`default_nettype none
`timescale 1ns/1ps

`include "radio_core_config.svh"

module ctrl_decoder (
  input  logic                      radio_clk,
  input  logic                      radio_rst,
  input  radio_ctrl_pkg::ctrl_req_t ctrl_req,
  output radio_ctrl_pkg::ctrl_req_t general_req,
  output radio_ctrl_pkg::ctrl_req_t tx_gain_req,
  output radio_ctrl_pkg::ctrl_req_t rx_gain_req,
  output logic                      unmapped
);

  import radio_ctrl_pkg::*;

  ctrl_req_t    req_q;
  ctrl_target_e target;

  // Only the opcode needs clearing, address and data follow it
  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      req_q.op <= CTRL_OP_IDLE;
    end else begin
      req_q <= ctrl_req;
    end
  end

  assign target = ctrl_target_e'(req_q.addr[`WIN_SEL_LSB+1:`WIN_SEL_LSB]);

  // ------------------------------
  // Per-target request
  // ------------------------------

  // Window bits are stripped so each target sees its own offset
  function automatic ctrl_req_t route(input ctrl_req_t req, input ctrl_target_e sel,
                                      input ctrl_target_e tgt);
    ctrl_req_t r;
    r.op                       = (tgt == sel) ? req.op : CTRL_OP_IDLE;
    r.addr                     = '0;
    r.addr[`WIN_SEL_LSB-1:0]   = req.addr[`WIN_SEL_LSB-1:0];
    r.data                     = req.data;
    return r;
  endfunction

  assign general_req = route(req_q, TGT_GENERAL, target);
  assign tx_gain_req = route(req_q, TGT_TX_GAIN, target);
  assign rx_gain_req = route(req_q, TGT_RX_GAIN, target);

  // Fourth window has no target, the merge answers it
  assign unmapped = (target == TGT_UNMAPPED) && (req_q.op != CTRL_OP_IDLE);

endmodule

`default_nettype wire

/* hdl/loopback_control.sv */
// General registers of the radio core and the TX-to-RX loopback select in front of the RX gain
`default_nettype none
`timescale 1ns/1ps

`include "radio_core_config.svh"

module loopback_control (
  input  logic                           radio_clk,
  input  logic                           radio_rst,
  input  radio_ctrl_pkg::ctrl_req_t      req,
  output radio_ctrl_pkg::ctrl_resp_t     resp,
  input  radio_sample_pkg::sample_beat_t radio_tx,
  input  radio_sample_pkg::sample_beat_t radio_rx,
  output radio_sample_pkg::sample_beat_t rx_src
);

  import radio_ctrl_pkg::*;
  import radio_sample_pkg::*;

  // Sample width in the upper half, samples per cycle in the lower half
  localparam logic [`CTRL_DATA_W-1:0] RADIO_WIDTH_VAL = {16'(`SAMP_W), 16'(`NSPC)};
  // Bit 0 TX gain, bit 1 RX gain, both always built
  localparam logic [`CTRL_DATA_W-1:0] FEATURES_VAL = 32'h0000_0003;

  logic         loopback_en;
  logic         loopback_wr;
  ctrl_resp_t   resp_d;
  sample_beat_t tx_to_rx_q;

  // ------------------------------
  // Register decode
  // ------------------------------

  always_comb begin
    resp_d.ack    = (req.op != CTRL_OP_IDLE);
    resp_d.status = STS_CMDERR;
    resp_d.data   = '0;
    loopback_wr   = 1'b0;
    case (req.addr)
      `REG_LOOPBACK_EN: begin
        resp_d.status = STS_OKAY;
        if (req.op == CTRL_OP_WRITE) begin
          loopback_wr = 1'b1;
        end else if (req.op == CTRL_OP_READ) begin
          resp_d.data[0] = loopback_en;
        end
      end
      // Read-only, a write falls through as an error
      `REG_RADIO_WIDTH: begin
        if (req.op == CTRL_OP_READ) begin
          resp_d.status = STS_OKAY;
          resp_d.data   = RADIO_WIDTH_VAL;
        end
      end
      `REG_FEATURES_PRESENT: begin
        if (req.op == CTRL_OP_READ) begin
          resp_d.status = STS_OKAY;
          resp_d.data   = FEATURES_VAL;
        end
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      resp        <= '0;
      loopback_en <= 1'b0;
    end else begin
      resp <= resp_d;
      if (loopback_wr) begin
        loopback_en <= req.data[0];
      end
    end
  end

  // ------------------------------
  // TX to RX loopback
  // ------------------------------

  // Register breaks the path from the TX gain into the RX gain
  always_ff @(posedge radio_clk) begin
    tx_to_rx_q <= radio_tx;
  end

  // Switching mid-stream is not glitch free
  assign rx_src = loopback_en ? tx_to_rx_q : radio_rx;

endmodule

`default_nettype wire

/* hdl/complex_gain.sv */
// Register-programmed complex gain on a strobed sample stream, one instance per sample direction
`default_nettype none
`timescale 1ns/1ps

`include "radio_core_config.svh"

module complex_gain (
  input  logic                           radio_clk,
  input  logic                           radio_rst,
  input  radio_ctrl_pkg::ctrl_req_t      req,
  output radio_ctrl_pkg::ctrl_resp_t     resp,
  input  radio_sample_pkg::sample_beat_t din,
  output radio_sample_pkg::sample_beat_t dout
);

  import radio_ctrl_pkg::*;
  import radio_sample_pkg::*;

  localparam int PROD_W = 2 * `COMP_W;
  localparam int SUM_W  = PROD_W + 1;

  // Real part 1.0, imaginary part 0
  localparam logic [`CTRL_DATA_W-1:0] COEFF_RESET = {16'(1 << `GAIN_FRAC_BITS), 16'h0000};

  localparam logic signed [SUM_W-1:0] SAT_MAX = SUM_W'((2 ** (`COMP_W - 1)) - 1);
  localparam logic signed [SUM_W-1:0] SAT_MIN = SUM_W'(-(2 ** (`COMP_W - 1)));

  logic [`CTRL_DATA_W-1:0]    coeff_q;
  logic                       coeff_wr;
  ctrl_resp_t                 resp_d;
  logic signed [`COMP_W-1:0]  gr;
  logic signed [`COMP_W-1:0]  gi;

  logic signed [PROD_W-1:0]   i_gr;
  logic signed [PROD_W-1:0]   q_gi;
  logic signed [PROD_W-1:0]   i_gi;
  logic signed [PROD_W-1:0]   q_gr;
  logic signed [SUM_W-1:0]    sum_i;
  logic signed [SUM_W-1:0]    sum_q;
  iq_sample_t                 out_iq;
  logic [`GAIN_LATENCY-1:0]   stb_sr;

  // ------------------------------
  // Coefficient register
  // ------------------------------

  always_comb begin
    resp_d.ack    = (req.op != CTRL_OP_IDLE);
    resp_d.status = STS_CMDERR;
    resp_d.data   = '0;
    coeff_wr      = 1'b0;
    if (req.addr == `REG_CGAIN_COEFF) begin
      resp_d.status = STS_OKAY;
      if (req.op == CTRL_OP_WRITE) begin
        coeff_wr = 1'b1;
      end else if (req.op == CTRL_OP_READ) begin
        resp_d.data = coeff_q;
      end
    end
  end

  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      resp    <= '0;
      coeff_q <= COEFF_RESET;
    end else begin
      resp <= resp_d;
      if (coeff_wr) begin
        coeff_q <= req.data;
      end
    end
  end

  assign gr = coeff_q[2*`COMP_W-1:`COMP_W];
  assign gi = coeff_q[`COMP_W-1:0];

  // ------------------------------
  // Sample pipeline
  // ------------------------------

  // Floor rounding from the arithmetic shift, then clip to the component range
  function automatic logic signed [`COMP_W-1:0] saturate(input logic signed [SUM_W-1:0] v);
    logic signed [SUM_W-1:0] s;
    s = v >>> `GAIN_FRAC_BITS;
    if (s > SAT_MAX) begin
      return SAT_MAX[`COMP_W-1:0];
    end else if (s < SAT_MIN) begin
      return SAT_MIN[`COMP_W-1:0];
    end
    return s[`COMP_W-1:0];
  endfunction

  // Multiply, sum, shift and saturate
  always_ff @(posedge radio_clk) begin
    i_gr     <= din.iq.i * gr;
    q_gi     <= din.iq.q * gi;
    i_gi     <= din.iq.i * gi;
    q_gr     <= din.iq.q * gr;
    sum_i    <= i_gr - q_gi;
    sum_q    <= i_gi + q_gr;
    out_iq.i <= saturate(sum_i);
    out_iq.q <= saturate(sum_q);
  end

  // Strobe walks alongside the data, one bit per stage
  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      stb_sr <= '0;
    end else begin
      stb_sr <= {stb_sr[`GAIN_LATENCY-2:0], din.stb};
    end
  end

  assign dout.stb = stb_sr[`GAIN_LATENCY-1];
  assign dout.iq  = out_iq;

endmodule

`default_nettype wire

/* hdl/ctrl_response_merge.sv */
// Merges the target responses and the unmapped flag into the single registered control reply
`default_nettype none
`timescale 1ns/1ps

module ctrl_response_merge (
  input  logic                       radio_clk,
  input  logic                       radio_rst,
  input  radio_ctrl_pkg::ctrl_resp_t general_resp,
  input  radio_ctrl_pkg::ctrl_resp_t tx_gain_resp,
  input  radio_ctrl_pkg::ctrl_resp_t rx_gain_resp,
  input  logic                       unmapped,
  output radio_ctrl_pkg::ctrl_resp_t ctrl_resp
);

  import radio_ctrl_pkg::*;

  ctrl_resp_t resp_d;
  logic       unmapped_q;

  // At most one source is active per request
  always_comb begin
    resp_d.ack = general_resp.ack | tx_gain_resp.ack | rx_gain_resp.ack | unmapped_q;

    // Idle targets hold their data at zero, so OR is enough
    resp_d.data = general_resp.data | tx_gain_resp.data | rx_gain_resp.data;

    if (unmapped_q) begin
      resp_d.status = STS_CMDERR;
      resp_d.data   = '0;
    end else if (tx_gain_resp.ack) begin
      resp_d.status = tx_gain_resp.status;
    end else if (rx_gain_resp.ack) begin
      resp_d.status = rx_gain_resp.status;
    end else if (general_resp.ack) begin
      resp_d.status = general_resp.status;
    end else begin
      resp_d.status = STS_OKAY;
    end
  end

  // Unmapped pulse delayed by the target stage it skips
  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      ctrl_resp  <= '0;
      unmapped_q <= 1'b0;
    end else begin
      ctrl_resp  <= resp_d;
      unmapped_q <= unmapped;
    end
  end

endmodule

`default_nettype wire

/* hdl/radio_core.sv */
// Top level of the single-channel radio sample path, instantiated by the testbench as the DUT
`default_nettype none
`timescale 1ns/1ps

module radio_core (
  input  logic                           radio_clk,
  input  logic                           radio_rst,
  input  radio_ctrl_pkg::ctrl_req_t      ctrl_req,
  output radio_ctrl_pkg::ctrl_resp_t     ctrl_resp,
  input  radio_sample_pkg::sample_beat_t tx_in,
  output radio_sample_pkg::sample_beat_t radio_tx,
  input  radio_sample_pkg::sample_beat_t radio_rx,
  output radio_sample_pkg::sample_beat_t rx_out
);

  import radio_ctrl_pkg::*;
  import radio_sample_pkg::*;

  ctrl_req_t    general_req;
  ctrl_req_t    tx_gain_req;
  ctrl_req_t    rx_gain_req;
  ctrl_resp_t   general_resp;
  ctrl_resp_t   tx_gain_resp;
  ctrl_resp_t   rx_gain_resp;
  logic         unmapped;
  sample_beat_t rx_src;

  // ------------------------------
  // Control path
  // ------------------------------

  ctrl_decoder ctrl_decoder_i (
    .radio_clk   (radio_clk),
    .radio_rst   (radio_rst),
    .ctrl_req    (ctrl_req),
    .general_req (general_req),
    .tx_gain_req (tx_gain_req),
    .rx_gain_req (rx_gain_req),
    .unmapped    (unmapped)
  );

  ctrl_response_merge ctrl_response_merge_i (
    .radio_clk    (radio_clk),
    .radio_rst    (radio_rst),
    .general_resp (general_resp),
    .tx_gain_resp (tx_gain_resp),
    .rx_gain_resp (rx_gain_resp),
    .unmapped     (unmapped),
    .ctrl_resp    (ctrl_resp)
  );

  // ------------------------------
  // Sample path
  // ------------------------------

  complex_gain tx_gain_i (
    .radio_clk (radio_clk),
    .radio_rst (radio_rst),
    .req       (tx_gain_req),
    .resp      (tx_gain_resp),
    .din       (tx_in),
    .dout      (radio_tx)
  );

  loopback_control loopback_control_i (
    .radio_clk (radio_clk),
    .radio_rst (radio_rst),
    .req       (general_req),
    .resp      (general_resp),
    .radio_tx  (radio_tx),
    .radio_rx  (radio_rx),
    .rx_src    (rx_src)
  );

  complex_gain rx_gain_i (
    .radio_clk (radio_clk),
    .radio_rst (radio_rst),
    .req       (rx_gain_req),
    .resp      (rx_gain_resp),
    .din       (rx_src),
    .dout      (rx_out)
  );

endmodule

`default_nettype wire

/* verification/radio_core_properties.sv */
// Concurrent checks on the radio core control handshake and TX sample timing, bound into the DUT
`default_nettype none
`timescale 1ns/1ps

`include "radio_core_config.svh"

module radio_core_properties (
  input logic                           radio_clk,
  input logic                           radio_rst,
  input radio_ctrl_pkg::ctrl_req_t      ctrl_req,
  input radio_ctrl_pkg::ctrl_resp_t     ctrl_resp,
  input radio_sample_pkg::sample_beat_t tx_in,
  input radio_sample_pkg::sample_beat_t radio_tx
);

  import radio_ctrl_pkg::*;

  // ------------------------------
  // Control handshake
  // ------------------------------

  ack_after_request: assert property (@(posedge radio_clk) disable iff (radio_rst)
    (ctrl_req.op != CTRL_OP_IDLE) |-> ##(`CTRL_LATENCY) ctrl_resp.ack)
    else $error("Control ack missing %0d cycles after a request", `CTRL_LATENCY);

  ack_has_request: assert property (@(posedge radio_clk) disable iff (radio_rst)
    ctrl_resp.ack |-> $past(ctrl_req.op != CTRL_OP_IDLE, `CTRL_LATENCY))
    else $error("Control ack without a matching request");

  // One reply per request, never back to back
  ack_single_cycle: assert property (@(posedge radio_clk) disable iff (radio_rst)
    ctrl_resp.ack |=> !ctrl_resp.ack)
    else $error("Control ack in two consecutive cycles");

  // ------------------------------
  // TX sample path
  // ------------------------------

  tx_strobe_latency: assert property (@(posedge radio_clk) disable iff (radio_rst)
    tx_in.stb |-> ##(`GAIN_LATENCY) radio_tx.stb)
    else $error("radio_tx strobe missing %0d cycles after tx_in strobe", `GAIN_LATENCY);

endmodule

bind radio_core radio_core_properties props_i (
  .radio_clk (radio_clk),
  .radio_rst (radio_rst),
  .ctrl_req  (ctrl_req),
  .ctrl_resp (ctrl_resp),
  .tx_in     (tx_in),
  .radio_tx  (radio_tx)
);

`default_nettype wire

/* verification/radio_core_tb.sv */
// Directed testbench for the radio core registers, both gain stages and the loopback path
`default_nettype none
`timescale 1ns/1ps

`include "radio_core_config.svh"

module radio_core_tb;

  import radio_ctrl_pkg::*;
  import radio_sample_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 16;
  localparam int STREAM_LEN   = 50;
  // Six streams with tails, about 25 register accesses of 5 cycles each
  localparam int TEST_CYCLES  = RESET_CYCLES + 6 * (STREAM_LEN + 10) + 25 * 5;
  localparam int MAX_CYCLES   = TEST_CYCLES + 200;
  localparam logic [19:0] TX_WIN = 20'(1 << `WIN_SEL_LSB);
  localparam logic [19:0] RX_WIN = 20'(2 << `WIN_SEL_LSB);
  localparam logic [19:0] BAD_WIN = 20'(3 << `WIN_SEL_LSB);
  localparam int MODE_TX   = 0;
  localparam int MODE_RX   = 1;
  localparam int MODE_LOOP = 2;

  logic         radio_clk;
  logic         radio_rst;
  ctrl_req_t    ctrl_req;
  ctrl_resp_t   ctrl_resp;
  sample_beat_t tx_in;
  sample_beat_t radio_tx;
  sample_beat_t radio_rx;
  sample_beat_t rx_out;
  logic [31:0]  lfsr;
  logic [31:0]  tx_coeff;
  logic [31:0]  rx_coeff;
  int           cycle_count;

  radio_core uut (
    .radio_clk (radio_clk),
    .radio_rst (radio_rst),
    .ctrl_req  (ctrl_req),
    .ctrl_resp (ctrl_resp),
    .tx_in     (tx_in),
    .radio_tx  (radio_tx),
    .radio_rx  (radio_rx),
    .rx_out    (rx_out)
  );

  initial begin
    radio_clk = 1'b0;
    forever #(CLK_PERIOD / 2) radio_clk = ~radio_clk;
  end

  // ------------------------------
  // Helpers
  // ------------------------------

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Run stopped at %0t", $time);
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // Galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [15:0] clip16(input longint v);
    if (v > 32767) begin
      return 16'h7fff;
    end else if (v < -32768) begin
      return 16'h8000;
    end
    return v[15:0];
  endfunction

  // Complex product with the Q1.14 coefficient, floor then clip
  function automatic logic [31:0] apply_gain(input logic [31:0] iq, input logic [31:0] coeff);
    longint gr;
    longint gi;
    longint si;
    longint sq;
    gr = $signed(coeff[31:16]);
    gi = $signed(coeff[15:0]);
    si = $signed(iq[31:16]);
    sq = $signed(iq[15:0]);
    return {clip16((si * gr - sq * gi) >>> `GAIN_FRAC_BITS),
            clip16((si * gi + sq * gr) >>> `GAIN_FRAC_BITS)};
  endfunction

  // One request, then wait for its ack and check latency, status and data
  task automatic control_access(input ctrl_op_e op, input logic [19:0] addr,
                                input logic [31:0] wdata, input ctrl_status_e exp_status,
                                input logic [31:0] exp_data);
    int waited;
    @(negedge radio_clk);
    ctrl_req.op   = op;
    ctrl_req.addr = addr;
    ctrl_req.data = wdata;
    @(negedge radio_clk);
    ctrl_req = '0;
    waited = 1;
    while (!ctrl_resp.ack && waited < 4 * `CTRL_LATENCY) begin
      @(negedge radio_clk);
      waited++;
    end
    if (!ctrl_resp.ack) begin
      $display("No control ack for address 0x%05h after %0d cycles", addr, waited);
      abort_run();
    end
    compare("ack latency", waited, `CTRL_LATENCY);
    compare("ctrl_resp.status", ctrl_resp.status, exp_status);
    compare("ctrl_resp.data", ctrl_resp.data, exp_data);
  endtask

  // Drives random beats and checks each output beat against a model delay line
  task automatic run_stream(input int mode, input bit full_scale);
    logic [31:0]  pipe_val [0:7];
    logic         pipe_stb [0:7];
    logic [31:0]  r;
    int           lat;
    string        out_name;
    sample_beat_t got;
    sample_beat_t beat;
    sample_beat_t decoy;
    lat = (mode == MODE_LOOP) ? `GAIN_LATENCY * 2 + 1 : `GAIN_LATENCY;
    out_name = (mode == MODE_TX) ? "radio_tx" : "rx_out";
    for (int k = 0; k < 8; k++) begin
      pipe_stb[k] = 1'b0;
      pipe_val[k] = '0;
    end
    for (int step = 0; step < STREAM_LEN + lat; step++) begin
      @(negedge radio_clk);
      got = (mode == MODE_TX) ? radio_tx : rx_out;
      compare({out_name, ".stb"}, got.stb, pipe_stb[lat-1]);
      if (pipe_stb[lat-1]) begin
        compare({out_name, ".iq"}, got.iq, pipe_val[lat-1]);
      end
      for (int k = 7; k > 0; k--) begin
        pipe_stb[k] = pipe_stb[k-1];
        pipe_val[k] = pipe_val[k-1];
      end
      beat  = '0;
      decoy = '0;
      if (step < STREAM_LEN) begin
        r = random_bits(1);
        beat.stb = r[0];
        if (full_scale) begin
          r = random_bits(2);
          beat.iq = {r[1] ? 16'h7fff : 16'h8000, r[0] ? 16'h7fff : 16'h8000};
        end else begin
          r = random_bits(32);
          beat.iq = r;
        end
        r = random_bits(32);
        decoy = {1'b1, r};
      end
      pipe_stb[0] = beat.stb;
      if (mode == MODE_TX) begin
        pipe_val[0] = apply_gain(beat.iq, tx_coeff);
        tx_in = beat;
      end else if (mode == MODE_RX) begin
        pipe_val[0] = apply_gain(beat.iq, rx_coeff);
        radio_rx = beat;
      end else begin
        pipe_val[0] = apply_gain(apply_gain(beat.iq, tx_coeff), rx_coeff);
        tx_in = beat;
        radio_rx = decoy;
      end
    end
  endtask

  task automatic write_coeff(input logic [19:0] win, input logic [31:0] value);
    control_access(CTRL_OP_WRITE, win | `REG_CGAIN_COEFF, value, STS_OKAY, '0);
  endtask

  // ------------------------------
  // Tests
  // ------------------------------

  task automatic test_reset_ident();
    compare("ctrl_resp.ack", ctrl_resp.ack, 1'b0);
    compare("radio_tx.stb", radio_tx.stb, 1'b0);
    compare("rx_out.stb", rx_out.stb, 1'b0);
    control_access(CTRL_OP_READ, `REG_LOOPBACK_EN, '0, STS_OKAY, 32'h0);
    control_access(CTRL_OP_READ, `REG_RADIO_WIDTH, '0, STS_OKAY, 32'h0020_0001);
    control_access(CTRL_OP_READ, `REG_FEATURES_PRESENT, '0, STS_OKAY, 32'h3);
  endtask

  task automatic test_register_access();
    write_coeff(TX_WIN, 32'h1234_abcd);
    control_access(CTRL_OP_READ, TX_WIN | `REG_CGAIN_COEFF, '0, STS_OKAY, 32'h1234_abcd);
    write_coeff(RX_WIN, 32'hc0de_0042);
    control_access(CTRL_OP_READ, RX_WIN | `REG_CGAIN_COEFF, '0, STS_OKAY, 32'hc0de_0042);
    control_access(CTRL_OP_WRITE, `REG_LOOPBACK_EN, 32'h1, STS_OKAY, '0);
    control_access(CTRL_OP_READ, `REG_LOOPBACK_EN, '0, STS_OKAY, 32'h1);
    control_access(CTRL_OP_WRITE, `REG_LOOPBACK_EN, 32'h0, STS_OKAY, '0);
    control_access(CTRL_OP_READ, `REG_LOOPBACK_EN, '0, STS_OKAY, 32'h0);
    control_access(CTRL_OP_READ, BAD_WIN, '0, STS_CMDERR, '0);
    control_access(CTRL_OP_WRITE, BAD_WIN | 20'h4, 32'hffff_ffff, STS_CMDERR, '0);
    control_access(CTRL_OP_READ, 20'h0_000c, '0, STS_CMDERR, '0);
    control_access(CTRL_OP_WRITE, `REG_RADIO_WIDTH, 32'h5555_aaaa, STS_CMDERR, '0);
    control_access(CTRL_OP_READ, `REG_RADIO_WIDTH, '0, STS_OKAY, 32'h0020_0001);
  endtask

  task automatic test_tx_gain();
    tx_coeff = random_bits(32);
    write_coeff(TX_WIN, tx_coeff);
    run_stream(MODE_TX, 1'b0);
    // Near plus and minus 2.0 drives both outputs into the clip
    tx_coeff = 32'h7fff_8000;
    write_coeff(TX_WIN, tx_coeff);
    run_stream(MODE_TX, 1'b1);
  endtask

  task automatic test_rx_gain();
    rx_coeff = random_bits(32);
    write_coeff(RX_WIN, rx_coeff);
    run_stream(MODE_RX, 1'b0);
    tx_coeff = random_bits(32);
    write_coeff(TX_WIN, tx_coeff);
    run_stream(MODE_RX, 1'b0);
  endtask

  task automatic test_loopback();
    control_access(CTRL_OP_WRITE, `REG_LOOPBACK_EN, 32'h1, STS_OKAY, '0);
    run_stream(MODE_LOOP, 1'b0);
    control_access(CTRL_OP_WRITE, `REG_LOOPBACK_EN, 32'h0, STS_OKAY, '0);
    repeat (8) @(negedge radio_clk);
    run_stream(MODE_RX, 1'b0);
  endtask

  // ------------------------------
  // Sequence and timeout
  // ------------------------------

  initial begin
    ctrl_req  = '0;
    tx_in     = '0;
    radio_rx  = '0;
    radio_rst = 1'b1;
    lfsr      = 32'h8e42_8d7e;
    tx_coeff  = 32'h4000_0000;
    rx_coeff  = 32'h4000_0000;
    repeat (RESET_CYCLES) @(negedge radio_clk);
    radio_rst = 1'b0;
    test_reset_ident();
    test_register_access();
    test_tx_gain();
    test_rx_gain();
    test_loopback();
    $display("TEST RESULT: PASS");
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge radio_clk);
      cycle_count++;
    end
    $display("Timeout, tests still running after %0d cycles", cycle_count);
    abort_run();
  end

endmodule

`default_nettype wire

/* radio_core.f */
+incdir+hdl
hdl/radio_ctrl_pkg.sv
hdl/radio_sample_pkg.sv
hdl/ctrl_decoder.sv
hdl/loopback_control.sv
hdl/complex_gain.sv
hdl/ctrl_response_merge.sv
hdl/radio_core.sv
verification/radio_core_properties.sv
verification/radio_core_tb.sv

/* Bender.yml */
package:
  name: radio_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/radio_ctrl_pkg.sv
      - hdl/radio_sample_pkg.sv
      - hdl/ctrl_decoder.sv
      - hdl/loopback_control.sv
      - hdl/complex_gain.sv
      - hdl/ctrl_response_merge.sv
      - hdl/radio_core.sv

  - target: simulation
    include_dirs:
      - hdl
    files:
      - verification/radio_core_properties.sv
      - verification/radio_core_tb.sv
